//--- compile.f
verilog/lotrPkg.sv
verilog/f2cIngress.sv
verilog/f2cEntry.sv
verilog/mroOrder.sv
verilog/f2cEgress.sv
verilog/f2cTop.sv
tests/f2cChecker.sv
tests/f2cTb.sv

//--- tests/f2cChecker.sv
//==========================================================
// Scoreboard for the ring controller testbench. Predicts core
// requests and ring responses from accepted ring beats and
// compares them at the falling edge, when all ports are steady
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cChecker
    import lotrPkg::*;
(
    input  wire logic                     qClk,
    input  wire logic                     rst,
    input  wire logic [DATA_W-1:0]        rspKey,      // Core model data rule
    input  wire logic                     expMatch,    // Table says beat is for this core
    input  wire logic                     expAccept,   // Table says a free entry exists
    input  wire tOpcode                   ringReqOpcode,
    input  wire logic [REQUESTOR_W-1:0]   ringReqRequestor,
    input  wire logic [ADDR_W-1:0]        ringReqAddress,
    input  wire logic [DATA_W-1:0]        ringReqData,
    input  wire logic                     ringRspValid,
    input  wire logic                     ringRspGrant,
    input  wire tOpcode                   ringRspOpcode,
    input  wire logic [REQUESTOR_W-1:0]   ringRspRequestor,
    input  wire logic [ADDR_W-1:0]        ringRspAddress,
    input  wire logic [DATA_W-1:0]        ringRspData,
    input  wire logic                     coreReqValid,
    input  wire tOpcode                   coreReqOpcode,
    input  wire logic [ADDR_W-1:0]        coreReqAddress,
    input  wire logic [DATA_W-1:0]        coreReqData,
    input  wire logic                     matchId,
    input  wire logic                     reqDropped
);

    logic [1:0]             expOpQ[$];        // Core side, arrival order
    logic [ADDR_W-1:0]      expAddrQ[$];
    logic [DATA_W-1:0]      expDataQ[$];
    logic [REQUESTOR_W-1:0] expRspReqQ[$];    // Ring side, reads only
    logic [ADDR_W-1:0]      expRspAddrQ[$];
    logic [ADDR_W-1:0]      rspAddr;
    logic                   dropDue   = 1'b0; // reqDropped due this cycle
    logic                   holdArmed = 1'b0; // Response seen without grant
    logic [REQUESTOR_W-1:0] heldReq;
    logic [ADDR_W-1:0]      heldAddr;
    logic [DATA_W-1:0]      heldData;
    int                     mismatches = 0;
    int                     failures   = 0;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got %0h expected %0h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic noteFailure(input string what);
        $display("ERROR time=%0t %s", $time, what);
        failures++;
    endtask

    function automatic int pendingCore();
        return expOpQ.size();
    endfunction

    function automatic int pendingRsp();
        return expRspAddrQ.size();
    endfunction

    function automatic int errorTotal();
        return mismatches + failures + expOpQ.size() + expRspAddrQ.size();
    endfunction

    task automatic printSummary();
        $display("Errors: %0d mismatches, %0d other, %0d core and %0d ring items never seen",
                 mismatches, failures, expOpQ.size(), expRspAddrQ.size());
    endtask

    //==========================================================
    // Per-cycle compare
    //==========================================================
    always @(negedge qClk) begin
        if (!rst) begin
            compare("matchId", matchId, expMatch);
            compare("reqDropped", reqDropped, dropDue);
            dropDue = expMatch && !expAccept;   // Pulse lands one cycle later
            if (coreReqValid && expOpQ.size() == 0) begin
                noteFailure("core request issued while none was expected");
            end else if (coreReqValid) begin
                compare("coreReqOpcode", coreReqOpcode, expOpQ.pop_front());
                compare("coreReqAddress", coreReqAddress, expAddrQ.pop_front());
                compare("coreReqData", coreReqData, expDataQ.pop_front());
            end
            if (holdArmed) begin   // Must not move while grant was low
                compare("ringRspValid (held)", ringRspValid, 1'b1);
                compare("ringRspRequestor (held)", ringRspRequestor, heldReq);
                compare("ringRspAddress (held)", ringRspAddress, heldAddr);
                compare("ringRspData (held)", ringRspData, heldData);
            end
            holdArmed = ringRspValid && !ringRspGrant;
            heldReq   = ringRspRequestor;
            heldAddr  = ringRspAddress;
            heldData  = ringRspData;
            if (ringRspValid && expRspAddrQ.size() == 0) begin
                noteFailure("ring response valid while no read was pending");
            end else if (ringRspValid && ringRspGrant) begin
                rspAddr = expRspAddrQ.pop_front();
                compare("ringRspOpcode", ringRspOpcode, RD_RSP);
                compare("ringRspRequestor", ringRspRequestor, expRspReqQ.pop_front());
                compare("ringRspAddress", ringRspAddress, rspAddr);
                compare("ringRspData", ringRspData, rspAddr ^ rspKey);
            end
            if (expAccept) begin
                expOpQ.push_back((ringReqOpcode == RD) ? RD : WR);   // Broadcast maps to WR
                expAddrQ.push_back(ringReqAddress);
                expDataQ.push_back(ringReqData);
                if (ringReqOpcode == RD) begin
                    expRspReqQ.push_back(ringReqRequestor);
                    expRspAddrQ.push_back(ringReqAddress);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/f2cTb.sv
//==========================================================
// Testbench for the fabric-to-core ring controller. Plays a
// table of ring beats, models the core and the ring arbiter,
// and leaves all comparing to the checker
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cTb
    import lotrPkg::*;
();

    localparam logic [CORE_ID_W-1:0] MY_CORE    = 8'h5A;
    localparam logic [DATA_W-1:0]    RSP_KEY    = 32'hC0DE_5EED;  // Read data = address ^ key
    localparam int                   CORE_DELAY = 6;              // Issue to read data, cycles
    localparam int                   TIMEOUT    = 200;
    localparam int                   MAX_BEATS  = 16;

    logic                   qClk             = 1'b0;
    logic                   rst              = 1'b1;
    logic [CORE_ID_W-1:0]   coreId           = MY_CORE;
    logic                   ringReqValid     = 1'b0;
    logic [REQUESTOR_W-1:0] ringReqRequestor = '0;
    tOpcode                 ringReqOpcode    = RD;
    logic [ADDR_W-1:0]      ringReqAddress   = '0;
    logic [DATA_W-1:0]      ringReqData      = '0;
    logic                   ringRspGrant     = 1'b0;
    logic                   coreRspValid     = 1'b0;
    tOpcode                 coreRspOpcode    = RD;
    logic [ADDR_W-1:0]      coreRspAddress   = '0;
    logic [DATA_W-1:0]      coreRspData      = '0;
    logic                   expMatch         = 1'b0;
    logic                   expAccept        = 1'b0;
    logic                   ringRspValid, coreReqValid, matchId, reqDropped;
    tOpcode                 ringRspOpcode, coreReqOpcode;
    logic [REQUESTOR_W-1:0] ringRspRequestor;
    logic [ADDR_W-1:0]      ringRspAddress, coreReqAddress;
    logic [DATA_W-1:0]      ringRspData, coreReqData;

    // Stimulus table, one row per ring beat
    tOpcode                 tOp[MAX_BEATS];
    logic [ADDR_W-1:0]      tAddr[MAX_BEATS];
    logic [DATA_W-1:0]      tData[MAX_BEATS];
    logic [REQUESTOR_W-1:0] tReq[MAX_BEATS];
    logic                   tMatch[MAX_BEATS];       // Beat is for this core
    logic                   tAccept[MAX_BEATS];
    int                     tGrantDelay[MAX_BEATS];  // Cycles of grant low, reads only
    int                     tIdle[MAX_BEATS];        // Quiet cycles after the beat
    int                     beatCount = 0;
    logic [ADDR_W-1:0]      rdAddrQ[$];              // Core model, reads in flight
    int                     rdDueQ[$];
    int                     cycle = 0;

    f2cTop DUT (.*);
    f2cChecker chk (.rspKey(RSP_KEY), .*);

    always #10 qClk = ~qClk;
    always @(posedge qClk) cycle <= cycle + 1;

    //==========================================================
    // Core model
    //==========================================================
    always @(negedge qClk) begin
        if (!rst && coreReqValid && coreReqOpcode == RD) begin
            rdAddrQ.push_back(coreReqAddress);
            rdDueQ.push_back(cycle + CORE_DELAY);
        end
    end

    always @(posedge qClk) begin
        #2;
        coreRspValid = 1'b0;   // One response per cycle, oldest read first
        if (!rst && rdAddrQ.size() > 0 && cycle >= rdDueQ[0]) begin
            rdDueQ.delete(0);
            coreRspAddress = rdAddrQ.pop_front();
            coreRspData    = coreRspAddress ^ RSP_KEY;
            coreRspOpcode  = RD_RSP;
            coreRspValid   = 1'b1;
        end
    end

    task automatic addBeat(input tOpcode op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [REQUESTOR_W-1:0] req,
                           input logic match, input logic accept, input int grantDelay,
                           input int idle);
        tOp[beatCount]         = op;
        tAddr[beatCount]       = addr;
        tData[beatCount]       = data;
        tReq[beatCount]        = req;
        tMatch[beatCount]      = match;
        tAccept[beatCount]     = accept;
        tGrantDelay[beatCount] = grantDelay;
        tIdle[beatCount]       = idle;
        beatCount++;
    endtask

    task automatic loadTable();
        // Other cores and ring RD_RSP are ignored, broadcast goes anywhere
        addBeat(WR,       32'h3300_0010, 32'h0000_1111, 10'h001, 1'b0, 1'b0, 0, 0);
        addBeat(RD_RSP,   32'h5A00_0020, 32'h0000_2222, 10'h002, 1'b0, 1'b0, 0, 1);
        addBeat(RD,       32'h1200_0030, 32'h0000_3333, 10'h003, 1'b0, 1'b0, 0, 2);
        addBeat(WR_BCAST, 32'h7700_0040, 32'hB0B0_0040, 10'h004, 1'b1, 1'b1, 0, 0);
        addBeat(WR,       32'h5A00_0050, 32'hA5A5_0050, 10'h005, 1'b1, 1'b1, 0, 0);
        addBeat(RD,       32'h5A00_0060, 32'h0000_0000, 10'h011, 1'b1, 1'b1, 0, 0);
        addBeat(WR,       32'h5A00_0070, 32'h1234_5678, 10'h006, 1'b1, 1'b1, 0, 20);
        // Four reads fill the buffer, two more matching beats drop
        addBeat(RD,       32'h5A00_0100, 32'h0000_0000, 10'h021, 1'b1, 1'b1, 3, 0);
        addBeat(RD,       32'h5A00_0104, 32'h0000_0000, 10'h022, 1'b1, 1'b1, 0, 0);
        addBeat(RD,       32'h5A00_0108, 32'h0000_0000, 10'h023, 1'b1, 1'b1, 2, 0);
        addBeat(RD,       32'h5A00_010C, 32'h0000_0000, 10'h024, 1'b1, 1'b1, 1, 0);
        addBeat(WR,       32'h5A00_0200, 32'hDEAD_0200, 10'h025, 1'b1, 1'b0, 0, 0);
        addBeat(WR_BCAST, 32'h0000_0300, 32'hDEAD_0300, 10'h026, 1'b1, 1'b0, 0, 30);
        addBeat(RD,       32'h5A00_0400, 32'h0000_0000, 10'h031, 1'b1, 1'b1, 4, 0);
        addBeat(WR,       32'h5A00_0404, 32'h0F0F_0404, 10'h032, 1'b1, 1'b1, 0, 30);
    endtask

    task automatic driveBeats();
        @(posedge qClk);
        #2;
        for (int k = 0; k < beatCount; k++) begin
            ringReqValid     = 1'b1;
            ringReqOpcode    = tOp[k];
            ringReqAddress   = tAddr[k];
            ringReqData      = tData[k];
            ringReqRequestor = tReq[k];
            expMatch         = tMatch[k];
            expAccept        = tAccept[k];
            @(posedge qClk);
            #2;
            if (tIdle[k] > 0) begin
                ringReqValid = 1'b0;
                expMatch     = 1'b0;
                expAccept    = 1'b0;
                repeat (tIdle[k]) begin
                    @(posedge qClk);
                    #2;
                end
            end
        end
        ringReqValid = 1'b0;
        expMatch     = 1'b0;
        expAccept    = 1'b0;
    endtask

    // Ring arbiter, holds grant low for each read's table delay
    task automatic grantResponses();
        int waitCnt;
        for (int k = 0; k < beatCount; k++) begin
            if (tAccept[k] && tOp[k] == RD) begin
                waitCnt = 0;
                @(negedge qClk);
                while (!ringRspValid && waitCnt < TIMEOUT) begin
                    @(negedge qClk);
                    waitCnt++;
                end
                if (!ringRspValid) begin
                    chk.noteFailure("timed out waiting for ringRspValid");
                    return;
                end
                @(posedge qClk);
                repeat (tGrantDelay[k]) @(posedge qClk);
                #2;
                ringRspGrant = 1'b1;
                @(posedge qClk);   // Retires here
                #2;
                ringRspGrant = 1'b0;
            end
        end
    endtask

    initial begin
        int waitCnt;
        loadTable();
        repeat (10) @(posedge qClk);
        #2;
        rst = 1'b0;
        fork
            driveBeats();
            grantResponses();
        join
        waitCnt = 0;
        while (chk.pendingCore() > 0 && waitCnt < TIMEOUT) begin
            @(posedge qClk);
            waitCnt++;
        end
        if (chk.pendingCore() > 0) begin
            chk.noteFailure("timed out waiting for coreReqValid on expected core requests");
        end
        waitCnt = 0;
        while (chk.pendingRsp() > 0 && waitCnt < TIMEOUT) begin
            @(posedge qClk);
            waitCnt++;
        end
        if (chk.pendingRsp() > 0) begin
            chk.noteFailure("timed out waiting for expected ring responses");
        end
        chk.printSummary();
        if (chk.errorTotal() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/f2cEgress.sv
//==========================================================
// Output muxes. Turns the oldest picks into the ring
// response and the core request fields
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cEgress
    import lotrPkg::*;
(
    input  wire logic [ENTRIES_NUM-1:0]                 oldestRsp,
    input  wire logic [ENTRIES_NUM-1:0]                 oldestCoreReq,
    input  wire tEntryState [ENTRIES_NUM-1:0]           entryState,
    input  wire logic [ENTRIES_NUM-1:0][REQUESTOR_W-1:0] entryRequestor,
    input  wire logic [ENTRIES_NUM-1:0][ADDR_W-1:0]     entryAddress,
    input  wire logic [ENTRIES_NUM-1:0][DATA_W-1:0]     entryData,
    output logic                                        ringRspValid,
    output logic [REQUESTOR_W-1:0]                      ringRspRequestor,
    output tOpcode                                      ringRspOpcode,
    output logic [ADDR_W-1:0]                           ringRspAddress,
    output logic [DATA_W-1:0]                           ringRspData,
    output logic                                        coreReqValid,
    output tOpcode                                      coreReqOpcode,
    output logic [ADDR_W-1:0]                           coreReqAddress,
    output logic [DATA_W-1:0]                           coreReqData
);

    logic [ENTRY_IDX_W-1:0] rspIdx;
    logic [ENTRY_IDX_W-1:0] coreIdx;

    // One-hot to index
    always_comb begin
        rspIdx  = '0;
        coreIdx = '0;
        for (int i = 0; i < ENTRIES_NUM; i++) begin
            if (oldestRsp[i])     rspIdx  |= ENTRY_IDX_W'(i);
            if (oldestCoreReq[i]) coreIdx |= ENTRY_IDX_W'(i);
        end
    end

    // Ring side, read data going back
    assign ringRspValid     = (entryState[rspIdx] == READ_RDY);
    assign ringRspRequestor = entryRequestor[rspIdx];
    assign ringRspOpcode    = RD_RSP;
    assign ringRspAddress   = entryAddress[rspIdx];
    assign ringRspData      = entryData[rspIdx];

    // Core side, no back-pressure
    assign coreReqValid   = (entryState[coreIdx] == READ) || (entryState[coreIdx] == WRITE);
    assign coreReqOpcode  = (entryState[coreIdx] == READ) ? RD : WR;   // Broadcast is WR
    assign coreReqAddress = entryAddress[coreIdx];
    assign coreReqData    = entryData[coreIdx];

endmodule

`default_nettype wire

//--- verilog/f2cEntry.sv
//==========================================================
// One fabric-to-core buffer entry. Runs the request FSM and
// keeps requestor, address and data until the entry frees
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cEntry
    import lotrPkg::*;
(
    input  wire logic                     qClk,
    input  wire logic                     rst,
    input  wire logic                     allocEn,
    input  wire tOpcode                   allocOpcode,
    input  wire logic [REQUESTOR_W-1:0]   allocRequestor,
    input  wire logic [ADDR_W-1:0]        allocAddress,
    input  wire logic [DATA_W-1:0]        allocData,
    input  wire logic                     rspMatch,
    input  wire logic [DATA_W-1:0]        rspData,
    input  wire logic                     coreIssue,   // Oldest to core this cycle
    input  wire logic                     rspRetire,   // Granted onto the ring
    output tEntryState                    state,
    output logic                          nextFree,
    output logic [REQUESTOR_W-1:0]        requestor,
    output logic [ADDR_W-1:0]             address,
    output logic [DATA_W-1:0]             data
);

    tEntryState nextState;

    //==========================================================
    // Next state
    //==========================================================
    always_comb begin
        nextState = state;   // Hold by default
        case (state)
            FREE: begin
                if (allocEn) begin
                    case (allocOpcode)
                        RD:       nextState = READ;
                        WR:       nextState = WRITE;
                        WR_BCAST: nextState = WRITE;   // Core sees a plain write
                        default:  nextState = FREE;    // Ring RD_RSP is never allocated
                    endcase
                end
            end
            WRITE:      if (coreIssue) nextState = FREE;
            READ:       if (coreIssue) nextState = READ_PRGRS;
            READ_PRGRS: if (rspMatch)  nextState = READ_RDY;
            READ_RDY:   if (rspRetire) nextState = FREE;
            default:    nextState = FREE;
        endcase
    end

    assign nextFree = (nextState == FREE);   // Dealloc tap for age order

    always_ff @(posedge qClk) begin
        if (rst) begin
            state <= FREE;
        end else begin
            state <= nextState;
        end
    end

    //==========================================================
    // Payload
    //==========================================================
    always_ff @(posedge qClk) begin
        if (allocEn) begin
            requestor <= allocRequestor;
            address   <= allocAddress;
        end
        if (allocEn) begin
            data <= allocData;      // Write data
        end else if (rspMatch) begin
            data <= rspData;        // Read data from the core
        end
    end

    allocOnFree: assert property (@(posedge qClk) disable iff (rst) allocEn |-> state == FREE);

endmodule

`default_nettype wire

//--- verilog/f2cIngress.sv
//==========================================================
// Ring request decode for this core. Picks the lowest free
// entry for an accepted beat and steers core read data to
// the lowest waiting entry with the same address
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cIngress
    import lotrPkg::*;
(
    input  wire logic                                 qClk,
    input  wire logic                                 rst,
    input  wire logic [CORE_ID_W-1:0]                 coreId,
    input  wire logic                                 ringReqValid,
    input  wire logic [REQUESTOR_W-1:0]               ringReqRequestor,
    input  wire tOpcode                               ringReqOpcode,
    input  wire logic [ADDR_W-1:0]                    ringReqAddress,
    input  wire logic [DATA_W-1:0]                    ringReqData,
    input  wire tEntryState [ENTRIES_NUM-1:0]         entryState,
    input  wire logic [ENTRIES_NUM-1:0][ADDR_W-1:0]   entryAddress,
    input  wire logic                                 coreRspValid,
    input  wire tOpcode                               coreRspOpcode,
    input  wire logic [ADDR_W-1:0]                    coreRspAddress,
    input  wire logic [DATA_W-1:0]                    coreRspData,
    output logic                                      matchId,
    output logic                                      reqDropped,
    output logic [ENTRIES_NUM-1:0]                    allocEn,
    output tOpcode                                    allocOpcode,
    output logic [REQUESTOR_W-1:0]                    allocRequestor,
    output logic [ADDR_W-1:0]                         allocAddress,
    output logic [DATA_W-1:0]                         allocData,
    output logic [ENTRIES_NUM-1:0]                    rspMatch,
    output logic [DATA_W-1:0]                         rspData
);

    logic [ENTRIES_NUM-1:0] freeVec;
    logic [ENTRIES_NUM-1:0] firstFree;

    // Own core id, or a broadcast write; ring RD_RSP never taken
    assign matchId = ringReqValid && (ringReqOpcode != RD_RSP) &&
                     ((ringReqAddress[ADDR_W-1 -: CORE_ID_W] == coreId) ||
                      (ringReqOpcode == WR_BCAST));

    always_comb begin
        firstFree = '0;
        rspMatch  = '0;
        for (int i = ENTRIES_NUM - 1; i >= 0; i--) begin   // Lowest index wins
            freeVec[i] = (entryState[i] == FREE);
            if (freeVec[i]) begin
                firstFree    = '0;
                firstFree[i] = 1'b1;
            end
            if (coreRspValid && (coreRspOpcode == RD_RSP) &&
                (entryState[i] == READ_PRGRS) &&
                (entryAddress[i] == coreRspAddress)) begin
                rspMatch    = '0;
                rspMatch[i] = 1'b1;
            end
        end
    end

    assign allocEn        = matchId ? firstFree : '0;
    assign allocOpcode    = ringReqOpcode;      // Shared by all entries
    assign allocRequestor = ringReqRequestor;
    assign allocAddress   = ringReqAddress;
    assign allocData      = ringReqData;
    assign rspData        = coreRspData;

    // Buffer full, beat lost
    always_ff @(posedge qClk) begin
        if (rst) begin
            reqDropped <= 1'b0;
        end else begin
            reqDropped <= matchId && !(|freeVec);
        end
    end

    // Core read data always lands on a waiting read
    rspOwned: assert property (@(posedge qClk) disable iff (rst)
        (coreRspValid && coreRspOpcode == RD_RSP) |-> (rspMatch != '0));

endmodule

`default_nettype wire

//--- verilog/f2cTop.sv
//==========================================================
// Fabric-to-core ring controller top. Ingress feeds the
// entry array, age order picks, egress drives ring and core
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module f2cTop
    import lotrPkg::*;
(
    input  wire logic                     qClk,
    input  wire logic                     rst,
    input  wire logic [CORE_ID_W-1:0]     coreId,
    // Ring in
    input  wire logic                     ringReqValid,
    input  wire logic [REQUESTOR_W-1:0]   ringReqRequestor,
    input  wire tOpcode                   ringReqOpcode,
    input  wire logic [ADDR_W-1:0]        ringReqAddress,
    input  wire logic [DATA_W-1:0]        ringReqData,
    // Ring out
    output logic                          ringRspValid,
    output logic [REQUESTOR_W-1:0]        ringRspRequestor,
    output tOpcode                        ringRspOpcode,
    output logic [ADDR_W-1:0]             ringRspAddress,
    output logic [DATA_W-1:0]             ringRspData,
    input  wire logic                     ringRspGrant,
    // Core out
    output logic                          coreReqValid,
    output tOpcode                        coreReqOpcode,
    output logic [ADDR_W-1:0]             coreReqAddress,
    output logic [DATA_W-1:0]             coreReqData,
    // Core in
    input  wire logic                     coreRspValid,
    input  wire tOpcode                   coreRspOpcode,
    input  wire logic [ADDR_W-1:0]        coreRspAddress,
    input  wire logic [DATA_W-1:0]        coreRspData,
    // Status
    output logic                          matchId,
    output logic                          reqDropped
);

    //==========================================================
    // Internal wiring
    //==========================================================
    logic [ENTRIES_NUM-1:0]                  allocEn, rspMatch;
    logic [ENTRIES_NUM-1:0]                  nextFree, maskRsp, maskCore;
    logic [ENTRIES_NUM-1:0]                  oldestRsp, oldestCoreReq, rspRetire;
    tOpcode                                  allocOpcode;
    logic [REQUESTOR_W-1:0]                  allocRequestor;
    logic [ADDR_W-1:0]                       allocAddress;
    logic [DATA_W-1:0]                       allocData, rspData;
    tEntryState [ENTRIES_NUM-1:0]            entryState;
    logic [ENTRIES_NUM-1:0][REQUESTOR_W-1:0] entryRequestor;
    logic [ENTRIES_NUM-1:0][ADDR_W-1:0]      entryAddress;
    logic [ENTRIES_NUM-1:0][DATA_W-1:0]      entryData;

    f2cIngress ingress (
        .qClk, .rst, .coreId,
        .ringReqValid, .ringReqRequestor, .ringReqOpcode, .ringReqAddress, .ringReqData,
        .entryState, .entryAddress,
        .coreRspValid, .coreRspOpcode, .coreRspAddress, .coreRspData,
        .matchId, .reqDropped, .allocEn,
        .allocOpcode, .allocRequestor, .allocAddress, .allocData,
        .rspMatch, .rspData
    );

    // Retire only when the arbiter takes it
    assign rspRetire = oldestRsp & {ENTRIES_NUM{ringRspGrant}};

    for (genvar i = 0; i < ENTRIES_NUM; i++) begin : genEntry
        f2cEntry entry (
            .qClk, .rst,
            .allocEn(allocEn[i]), .allocOpcode, .allocRequestor, .allocAddress, .allocData,
            .rspMatch(rspMatch[i]), .rspData,
            .coreIssue(oldestCoreReq[i]),   // Core always takes it
            .rspRetire(rspRetire[i]),
            .state(entryState[i]), .nextFree(nextFree[i]),
            .requestor(entryRequestor[i]), .address(entryAddress[i]), .data(entryData[i])
        );
        assign maskRsp[i]  = (entryState[i] == READ_RDY);
        assign maskCore[i] = (entryState[i] == READ) || (entryState[i] == WRITE);
    end

    mroOrder order (
        .qClk, .rst, .alloc(allocEn), .dealloc(nextFree),
        .maskRsp, .maskCore, .oldestRsp, .oldestCoreReq
    );

    f2cEgress egress (
        .oldestRsp, .oldestCoreReq,
        .entryState, .entryRequestor, .entryAddress, .entryData,
        .ringRspValid, .ringRspRequestor, .ringRspOpcode, .ringRspAddress, .ringRspData,
        .coreReqValid, .coreReqOpcode, .coreReqAddress, .coreReqData
    );

endmodule

`default_nettype wire

//--- verilog/lotrPkg.sv
//==========================================================
// Shared types and sizes for the fabric-to-core ring
// controller. Every RTL block and the testbench import it
//==========================================================
`default_nettype none

package lotrPkg;

    //==========================================================
    // Buffer and field sizes
    //==========================================================
    localparam int ENTRIES_NUM = 4;   // Buffer depth
    localparam int ENTRY_IDX_W = 2;   // Encoded entry index
    localparam int REQUESTOR_W = 10;
    localparam int CORE_ID_W   = 8;   // Also top address field width
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    //==========================================================
    // Ring and core opcodes
    //==========================================================
    typedef enum logic [1:0] {
        RD       = 2'b00,
        WR       = 2'b01,
        WR_BCAST = 2'b10,   // Taken by every core
        RD_RSP   = 2'b11
    } tOpcode;

    //==========================================================
    // Buffer entry FSM states
    //==========================================================
    typedef enum logic [2:0] {
        FREE       = 3'd0,
        READ       = 3'd1,  // Read waiting for the core
        WRITE      = 3'd2,  // Write waiting for the core
        READ_PRGRS = 3'd3,  // Read issued, data pending
        READ_RDY   = 3'd4   // Data back, waiting for grant
    } tEntryState;

endpackage

`default_nettype wire

//--- verilog/mroOrder.sv
//==========================================================
// Age matrix over the buffer entries. Reports the oldest
// ready read response and the oldest request for the core
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module mroOrder
    import lotrPkg::*;
(
    input  wire logic                     qClk,
    input  wire logic                     rst,
    input  wire logic [ENTRIES_NUM-1:0]   alloc,       // One-hot new entry
    input  wire logic [ENTRIES_NUM-1:0]   dealloc,     // Free after this edge
    input  wire logic [ENTRIES_NUM-1:0]   maskRsp,     // READ_RDY entries
    input  wire logic [ENTRIES_NUM-1:0]   maskCore,    // READ or WRITE entries
    output logic [ENTRIES_NUM-1:0]        oldestRsp,
    output logic [ENTRIES_NUM-1:0]        oldestCoreReq
);

    // older[i][j] set when entry i came before entry j
    logic [ENTRIES_NUM-1:0][ENTRIES_NUM-1:0] older;

    //==========================================================
    // Matrix update
    //==========================================================
    always_ff @(posedge qClk) begin
        if (rst) begin
            older <= '0;
        end else begin
            for (int i = 0; i < ENTRIES_NUM; i++) begin
                for (int j = 0; j < ENTRIES_NUM; j++) begin
                    if (i == j) begin
                        older[i][j] <= 1'b0;
                    end else if (alloc[j]) begin
                        older[i][j] <= !dealloc[i];   // Survivors older than newcomer
                    end else if (alloc[i]) begin
                        older[i][j] <= 1'b0;          // Newcomer older than nobody
                    end
                end
            end
        end
    end

    //==========================================================
    // Oldest pick, per mask
    //==========================================================
    always_comb begin
        for (int j = 0; j < ENTRIES_NUM; j++) begin
            oldestRsp[j]     = maskRsp[j];
            oldestCoreReq[j] = maskCore[j];
            for (int i = 0; i < ENTRIES_NUM; i++) begin
                if (maskRsp[i] && older[i][j]) begin
                    oldestRsp[j] = 1'b0;      // Someone older is waiting
                end
                if (maskCore[i] && older[i][j]) begin
                    oldestCoreReq[j] = 1'b0;
                end
            end
        end
    end

    rspOneHot:  assert property (@(posedge qClk) disable iff (rst) $onehot0(oldestRsp));
    coreOneHot: assert property (@(posedge qClk) disable iff (rst) $onehot0(oldestCoreReq));

endmodule

`default_nettype wire
